/* body_fifo.sv */
module body_fifo (
	input  logic                   CLK,
	input  logic                   RESET,
	input  logic                   push_i,
	input  gravsim_pkg::body_job_t push_job_i,
	input  logic                   pop_i,
	output logic                   full_o,
	output logic                   valid_o,
	output gravsim_pkg::body_job_t head_job_o
);

	typedef logic [$clog2(gravsim_pkg::FIFO_DEPTH)-1:0] ptr_t;
	typedef logic [$clog2(gravsim_pkg::FIFO_DEPTH):0]   cnt_t;

	gravsim_pkg::body_job_t mem [gravsim_pkg::FIFO_DEPTH];
	ptr_t                   wr_ptr;
	ptr_t                   rd_ptr;
	cnt_t                   count;

	always_ff @(posedge CLK)
	begin
		if (push_i)
			mem[wr_ptr] <= push_job_i;
	end

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push_i)
				wr_ptr <= (wr_ptr == ptr_t'(gravsim_pkg::FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_i)
				rd_ptr <= (rd_ptr == ptr_t'(gravsim_pkg::FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// simultaneous push and pop leaves the count alone
			if (push_i && !pop_i)
				count <= count + 1'b1;
			else if (pop_i && !push_i)
				count <= count - 1'b1;
		end
	end

	assign full_o     = (count == cnt_t'(gravsim_pkg::FIFO_DEPTH));
	assign valid_o    = (count != '0);
	assign head_job_o = mem[rd_ptr];

	a_no_overflow: assert property (@(posedge CLK) disable iff (RESET) push_i |-> !full_o);

	a_no_underflow: assert property (@(posedge CLK) disable iff (RESET) pop_i |-> valid_o);

endmodule

/* body_state_ram.sv */
module body_state_ram (
	input  logic                     CLK,
	input  logic                     load_we_i,
	input  gravsim_pkg::body_idx_t   load_idx_i,
	input  gravsim_pkg::body_state_t load_body_i,
	input  logic                     wb_we_i,
	input  gravsim_pkg::body_idx_t   wb_idx_i,
	input  gravsim_pkg::body_state_t wb_body_i,
	input  gravsim_pkg::body_idx_t   fetch_idx_i,
	input  gravsim_pkg::body_idx_t   rd_idx_i,
	output gravsim_pkg::body_state_t fetch_body_o,
	output gravsim_pkg::body_state_t rd_body_o
);

	gravsim_pkg::body_state_t mem [gravsim_pkg::MAX_BODIES];

	// one write port, loader wins
	always_ff @(posedge CLK)
	begin
		if (load_we_i)
		begin
			mem[load_idx_i] <= load_body_i;
		end
		else if (wb_we_i)
		begin
			mem[wb_idx_i] <= wb_body_i;
		end
	end

	// both read ports are asynchronous
	assign fetch_body_o = mem[fetch_idx_i];
	assign rd_body_o    = mem[rd_idx_i];

	// loader must stay idle while a step writes back
	a_no_write_collision: assert property (@(posedge CLK) !(load_we_i && wb_we_i));

	a_load_idx_range: assert property (@(posedge CLK)
		load_we_i |-> (load_idx_i < gravsim_pkg::body_idx_t'(gravsim_pkg::MAX_BODIES)));

	a_wb_idx_range: assert property (@(posedge CLK)
		wb_we_i |-> (wb_idx_i < gravsim_pkg::body_idx_t'(gravsim_pkg::MAX_BODIES)));

endmodule

/* euler_integrator.sv */
module euler_integrator (
	input  logic                     CLK,
	input  logic                     RESET,
	input  logic                     valid_i,
	input  gravsim_pkg::body_job_t   job_i,
	output logic                     pop_o,
	output logic                     wb_we_o,
	output gravsim_pkg::body_idx_t   wb_idx_o,
	output gravsim_pkg::body_state_t wb_body_o
);

	// a * DT, full 64-bit product, floor shift back to Q16.16
	function automatic gravsim_pkg::coord_t scale_dt(gravsim_pkg::coord_t a);
		logic signed [63:0] prod;
		prod = 64'(a) * 64'(gravsim_pkg::DT);
		return gravsim_pkg::coord_t'(prod >>> gravsim_pkg::FRAC_BITS);
	endfunction

	// base + rate * DT on each axis, wrapping at 32 bits
	function automatic gravsim_pkg::vec3_t advance(gravsim_pkg::vec3_t base,
		gravsim_pkg::vec3_t rate);
		gravsim_pkg::vec3_t res;
		res.x = base.x + scale_dt(rate.x);
		res.y = base.y + scale_dt(rate.y);
		res.z = base.z + scale_dt(rate.z);
		return res;
	endfunction

	logic                     s1_valid;
	gravsim_pkg::body_idx_t   s1_idx;
	gravsim_pkg::body_state_t s1_body;

	// never stalls, so every valid head is taken at once
	assign pop_o = valid_i;

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			s1_valid <= 1'b0;
			wb_we_o  <= 1'b0;
		end
		else
		begin
			s1_valid <= valid_i;
			wb_we_o  <= s1_valid;
		end
	end

	// stage 1 holds the new velocity
	always_ff @(posedge CLK)
	begin
		if (valid_i)
		begin
			s1_idx      <= job_i.idx;
			s1_body.pos <= job_i.state.pos;
			s1_body.vel <= advance(job_i.state.vel, job_i.state.acc);
			s1_body.acc <= job_i.state.acc;
		end
	end

	// stage 2 moves the body with the updated velocity
	always_ff @(posedge CLK)
	begin
		if (s1_valid)
		begin
			wb_idx_o      <= s1_idx;
			wb_body_o.pos <= advance(s1_body.pos, s1_body.vel);
			wb_body_o.vel <= s1_body.vel;
			wb_body_o.acc <= s1_body.acc;
		end
	end

endmodule

/* files.f */
gravsim_pkg.sv
body_state_ram.sv
step_sequencer.sv
body_fifo.sv
euler_integrator.sv
gravsim_top.sv
tb_gravsim.sv

/* gravsim_pkg.sv */
package gravsim_pkg;

	// signed Q16.16 number format
	localparam int FRAC_BITS = 16;
	typedef logic signed [31:0] coord_t;

	// body store limits
	localparam int MAX_BODIES = 10;
	typedef logic [3:0] body_idx_t;

	// 1/60 truncated to Q16.16
	localparam coord_t DT = 32'sh0000_0444;

	// jobs buffered between sequencer and integrator
	localparam int FIFO_DEPTH = 4;

	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t z;
	} vec3_t;

	typedef struct packed {
		vec3_t pos;
		vec3_t vel;
		vec3_t acc;
	} body_state_t;

	typedef struct packed {
		body_idx_t   idx;
		body_state_t state;
	} body_job_t;

	typedef enum logic [1:0] {WAIT, FETCH, DRAIN, DONE} seq_state_t;

endpackage

/* gravsim_top.sv */
module gravsim_top (
	input  logic                     CLK,
	input  logic                     RESET,
	input  logic                     start_i,
	input  gravsim_pkg::body_idx_t   num_bodies_i,
	input  logic                     load_we_i,
	input  gravsim_pkg::body_idx_t   load_idx_i,
	input  gravsim_pkg::body_state_t load_body_i,
	input  gravsim_pkg::body_idx_t   rd_idx_i,
	output logic                     busy_o,
	output logic                     done_o,
	output gravsim_pkg::body_state_t rd_body_o
);

	gravsim_pkg::body_idx_t   fetch_idx;
	gravsim_pkg::body_state_t fetch_body;
	logic                     push;
	gravsim_pkg::body_job_t   push_job;
	logic                     full;
	logic                     valid;
	gravsim_pkg::body_job_t   head_job;
	logic                     pop;
	logic                     wb_we;
	gravsim_pkg::body_idx_t   wb_idx;
	gravsim_pkg::body_state_t wb_body;

	body_state_ram u_ram (
		.CLK          (CLK),
		.load_we_i    (load_we_i),
		.load_idx_i   (load_idx_i),
		.load_body_i  (load_body_i),
		.wb_we_i      (wb_we),
		.wb_idx_i     (wb_idx),
		.wb_body_i    (wb_body),
		.fetch_idx_i  (fetch_idx),
		.rd_idx_i     (rd_idx_i),
		.fetch_body_o (fetch_body),
		.rd_body_o    (rd_body_o)
	);

	step_sequencer u_seq (
		.CLK          (CLK),
		.RESET        (RESET),
		.start_i      (start_i),
		.num_bodies_i (num_bodies_i),
		.fifo_full_i  (full),
		.fetch_body_i (fetch_body),
		.wb_done_i    (wb_we),
		.fetch_idx_o  (fetch_idx),
		.push_o       (push),
		.push_job_o   (push_job),
		.busy_o       (busy_o),
		.done_o       (done_o)
	);

	body_fifo u_fifo (
		.CLK        (CLK),
		.RESET      (RESET),
		.push_i     (push),
		.push_job_i (push_job),
		.pop_i      (pop),
		.full_o     (full),
		.valid_o    (valid),
		.head_job_o (head_job)
	);

	euler_integrator u_integ (
		.CLK       (CLK),
		.RESET     (RESET),
		.valid_i   (valid),
		.job_i     (head_job),
		.pop_o     (pop),
		.wb_we_o   (wb_we),
		.wb_idx_o  (wb_idx),
		.wb_body_o (wb_body)
	);

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert --top-module tb_gravsim -f files.f
./obj_dir/Vtb_gravsim | tee sim.log
grep -q "TB PASSED" sim.log

/* step_sequencer.sv */
module step_sequencer (
	input  logic                     CLK,
	input  logic                     RESET,
	input  logic                     start_i,
	input  gravsim_pkg::body_idx_t   num_bodies_i,
	input  logic                     fifo_full_i,
	input  gravsim_pkg::body_state_t fetch_body_i,
	input  logic                     wb_done_i,
	output gravsim_pkg::body_idx_t   fetch_idx_o,
	output logic                     push_o,
	output gravsim_pkg::body_job_t   push_job_o,
	output logic                     busy_o,
	output logic                     done_o
);

	gravsim_pkg::seq_state_t state, next_state;
	gravsim_pkg::body_idx_t  num_q;
	gravsim_pkg::body_idx_t  fetch_idx;
	gravsim_pkg::body_idx_t  wb_count;
	logic                    last_fetch;

	assign last_fetch = (fetch_idx == num_q - 1'b1);

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			state     <= gravsim_pkg::WAIT;
			num_q     <= '0;
			fetch_idx <= '0;
			wb_count  <= '0;
		end
		else
		begin
			state <= next_state;
			if (state == gravsim_pkg::WAIT && start_i)
			begin
				// body count is latched for the whole step
				num_q     <= num_bodies_i;
				fetch_idx <= '0;
				wb_count  <= '0;
			end
			else
			begin
				if (push_o)
					fetch_idx <= fetch_idx + 1'b1;
				if (wb_done_i)
					wb_count <= wb_count + 1'b1;
			end
		end
	end

	always_comb
	begin
		next_state = state;
		push_o     = 1'b0;
		case (state)
			gravsim_pkg::WAIT:
				if (start_i)
					next_state = gravsim_pkg::FETCH;
			gravsim_pkg::FETCH:
				// stall here while the FIFO is full
				if (!fifo_full_i)
				begin
					push_o = 1'b1;
					if (last_fetch)
						next_state = gravsim_pkg::DRAIN;
				end
			gravsim_pkg::DRAIN:
				if (wb_count == num_q)
					next_state = gravsim_pkg::DONE;
			gravsim_pkg::DONE:
				if (!start_i)
					next_state = gravsim_pkg::WAIT;
			default:
				next_state = gravsim_pkg::WAIT;
		endcase
	end

	assign fetch_idx_o      = fetch_idx;
	assign push_job_o.idx   = fetch_idx;
	assign push_job_o.state = fetch_body_i;

	assign busy_o = (state == gravsim_pkg::FETCH) || (state == gravsim_pkg::DRAIN);
	assign done_o = (state == gravsim_pkg::DONE);

	a_no_push_when_full: assert property (@(posedge CLK) disable iff (RESET)
		push_o |-> !fifo_full_i);

	// write-backs only belong to a running step
	a_wb_only_when_busy: assert property (@(posedge CLK) disable iff (RESET)
		wb_done_i |-> busy_o);

endmodule

/* tb_gravsim.sv */
module tb_gravsim;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NB             = gravsim_pkg::MAX_BODIES;
	localparam int NUM_ROWS       = 5;
	localparam int TIMEOUT_CYCLES = 200;
	localparam int HOLD_CYCLES    = 3;

	// 1/60 in Q16.16, truncated
	localparam longint ONE  = 65536;
	localparam longint DT_Q = ONE / 60;

	typedef struct packed {
		logic [7:0] num_bodies;
		logic [7:0] steps;
		logic       negative;
	} scenario_t;

	// num_bodies, steps, negative vel and acc
	scenario_t scen_tab [NUM_ROWS] = '{
		'{8'd10, 8'd1, 1'b0},
		'{8'd10, 8'd3, 1'b0},
		'{8'd6,  8'd2, 1'b0},
		'{8'd10, 8'd2, 1'b1},
		'{8'd1,  8'd1, 1'b0}
	};

	gravsim_pkg::body_state_t stim_tab [NUM_ROWS][NB];
	gravsim_pkg::body_state_t exp_tab  [NUM_ROWS][NB];

	// 32-bit words of a body, lowest first
	string field_names [9] = '{"acc.z", "acc.y", "acc.x", "vel.z", "vel.y", "vel.x",
		"pos.z", "pos.y", "pos.x"};

	logic                     CLK = 1'b0;
	logic                     RESET;
	logic                     start_i;
	gravsim_pkg::body_idx_t   num_bodies_i;
	logic                     load_we_i;
	gravsim_pkg::body_idx_t   load_idx_i;
	gravsim_pkg::body_state_t load_body_i;
	gravsim_pkg::body_idx_t   rd_idx_i;
	logic                     busy_o;
	logic                     done_o;
	gravsim_pkg::body_state_t rd_body_o;

	int mismatch_count = 0;
	int timeout_count  = 0;

	gravsim_top dut_i (
		.CLK          (CLK),
		.RESET        (RESET),
		.start_i      (start_i),
		.num_bodies_i (num_bodies_i),
		.load_we_i    (load_we_i),
		.load_idx_i   (load_idx_i),
		.load_body_i  (load_body_i),
		.rd_idx_i     (rd_idx_i),
		.busy_o       (busy_o),
		.done_o       (done_o),
		.rd_body_o    (rd_body_o)
	);

	always #5 CLK = ~CLK;

	// v * DT rounded toward minus infinity
	function automatic int mul_dt(input int v);
		longint p;
		longint q;
		p = longint'(v) * DT_Q;
		q = p / ONE;
		if (p < 0 && (p % ONE) != 0)
			q = q - 1;
		return int'(q);
	endfunction

	// one Euler step, velocity first
	function automatic gravsim_pkg::body_state_t ref_step(input gravsim_pkg::body_state_t b);
		gravsim_pkg::body_state_t r;
		r = b;
		r.vel.x = b.vel.x + mul_dt(b.acc.x);
		r.vel.y = b.vel.y + mul_dt(b.acc.y);
		r.vel.z = b.vel.z + mul_dt(b.acc.z);
		r.pos.x = b.pos.x + mul_dt(r.vel.x);
		r.pos.y = b.pos.y + mul_dt(r.vel.y);
		r.pos.z = b.pos.z + mul_dt(r.vel.z);
		return r;
	endfunction

	function automatic int neg_small();
		return 0 - int'($urandom_range(1, 400000));
	endfunction

	function automatic gravsim_pkg::body_state_t make_body(input logic negative);
		gravsim_pkg::body_state_t b;
		b = {$urandom(), $urandom(), $urandom(), $urandom(), $urandom(), $urandom(),
			$urandom(), $urandom(), $urandom()};
		if (negative)
		begin
			b.vel.x = neg_small();
			b.vel.y = neg_small();
			b.vel.z = neg_small();
			b.acc.x = neg_small();
			b.acc.y = neg_small();
			b.acc.z = neg_small();
		end
		return b;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_body(input int idx, input gravsim_pkg::body_state_t got,
		input gravsim_pkg::body_state_t exp);
		for (int w = 0; w < 9; w++)
			check_value($sformatf("rd_body_o[%0d].%s", idx, field_names[w]),
				got[w*32 +: 32], exp[w*32 +: 32]);
	endtask

	task automatic wait_done(input logic level, output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < TIMEOUT_CYCLES)
		begin
			@(negedge CLK);
			seen = (done_o == level);
			n++;
		end
		if (!seen)
		begin
			$display("Timeout: done_o did not go to %0b within %0d cycles", level,
				TIMEOUT_CYCLES);
			timeout_count++;
		end
	endtask

	task automatic run_step(output bit step_ok);
		@(negedge CLK);
		start_i = 1'b1;
		@(negedge CLK);
		check_value("busy_o", 32'(busy_o), 32'd1);
		wait_done(1'b1, step_ok);
		if (step_ok)
		begin
			// done is a level while start stays high
			repeat (HOLD_CYCLES)
			begin
				@(negedge CLK);
				check_value("done_o", 32'(done_o), 32'd1);
				check_value("busy_o", 32'(busy_o), 32'd0);
			end
			start_i = 1'b0;
			wait_done(1'b0, step_ok);
		end
	endtask

	initial
	begin
		bit ok;
		void'($urandom(35139));
		RESET        = 1'b1;
		start_i      = 1'b0;
		num_bodies_i = '0;
		load_we_i    = 1'b0;
		load_idx_i   = '0;
		load_body_i  = '0;
		rd_idx_i     = '0;

		for (int r = 0; r < NUM_ROWS; r++)
		begin
			for (int i = 0; i < NB; i++)
			begin
				stim_tab[r][i] = make_body(scen_tab[r].negative);
				if (scen_tab[r].negative && i == 0)
				begin
					// tiny negative rates, floor turns each product into -1
					stim_tab[r][i].vel = {3{32'hffff_ffff}};
					stim_tab[r][i].acc = {3{32'hffff_ffff}};
				end
				exp_tab[r][i] = stim_tab[r][i];
				if (i < int'(scen_tab[r].num_bodies))
					repeat (scen_tab[r].steps)
						exp_tab[r][i] = ref_step(exp_tab[r][i]);
			end
		end

		repeat (4) @(negedge CLK);
		RESET = 1'b0;
		@(negedge CLK);
		check_value("done_o", 32'(done_o), 32'd0);
		check_value("busy_o", 32'(busy_o), 32'd0);

		ok = 1'b1;
		for (int r = 0; r < NUM_ROWS && ok; r++)
		begin
			// every slot is loaded so idle bodies can be checked as well
			for (int i = 0; i < NB; i++)
			begin
				@(negedge CLK);
				load_we_i   = 1'b1;
				load_idx_i  = gravsim_pkg::body_idx_t'(i);
				load_body_i = stim_tab[r][i];
			end
			@(negedge CLK);
			load_we_i    = 1'b0;
			num_bodies_i = gravsim_pkg::body_idx_t'(scen_tab[r].num_bodies);
			for (int s = 0; s < int'(scen_tab[r].steps) && ok; s++)
				run_step(ok);
			for (int i = 0; i < NB && ok; i++)
			begin
				@(negedge CLK);
				rd_idx_i = gravsim_pkg::body_idx_t'(i);
				@(posedge CLK);
				check_body(i, rd_body_o, exp_tab[r][i]);
			end
		end

		$display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
